//--- src/csa_cfg.svh
`ifndef CSA_CFG_SVH
`define CSA_CFG_SVH

// ####################
// register window.
// ####################

// width of one register word.
`define CSA_DATA_WIDTH 32

// register address is CSA_ADDR_BITS+1 bits wide.
`define CSA_ADDR_BITS 10

// ####################
// accumulation bank.
// ####################

// number of accumulation units.
`define CSA_INST_NUM 5

// repeat count after reset or a zero write.
`define CSA_DEFAULT_TIMES 50000

`endif

//--- src/csa_reg_pkg.sv
`default_nettype none

`include "csa_cfg.svh"

package csa_reg_pkg;

	// register map.
	localparam logic [`CSA_ADDR_BITS:0] ADDR_CHANNEL = 0;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_IN_VALID = 1;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_OUT_VALID = 2;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_IN_DATA_0 = 3;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_IN_DATA_1 = 4;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_IN_DATA_2 = 5;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_IN_DATA_3 = 6;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_IN_DATA_4 = 7;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_OUT_DATA_0 = 8;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_OUT_DATA_1 = 9;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_OUT_DATA_2 = 10;
	localparam logic [`CSA_ADDR_BITS:0] ADDR_CALC_TIMES = 11;

	// upper half of an unmapped read.
	localparam logic [15:0] ERR_TAG = 16'hE000;

	typedef struct packed {
		logic wen;
		logic [`CSA_DATA_WIDTH/8-1:0] wstrb;
		logic [`CSA_ADDR_BITS:0] waddr;
		logic [`CSA_DATA_WIDTH-1:0] wdata;
	} csa_wr_req_t;

	typedef struct packed {
		logic ren;
		logic [`CSA_ADDR_BITS:0] raddr;
	} csa_rd_req_t;

endpackage

`default_nettype wire

//--- src/csa_calc_pkg.sv
`default_nettype none

package csa_calc_pkg;

	// five operand bytes, byte 0 in the low bits.
	typedef logic [4:0][7:0] csa_operands_t;

	// field view of a unit result.
	typedef struct packed {
		logic [15:0] unit_id;
		logic [15:0] total_hi;
		logic [15:0] total_lo;
	} csa_result_fields_t;

	// raw goes to the output FIFO, fields feed the snapshot.
	typedef union packed {
		logic [47:0] raw;
		csa_result_fields_t fields;
	} csa_result_u;

	typedef logic [31:0] csa_times_t;

endpackage

`default_nettype wire

//--- src/csa_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "csa_cfg.svh"

module csa_regfile (
	input wire logic axi_mm_clk,
	input wire logic rst_n,
	input wire csa_reg_pkg::csa_wr_req_t wr,
	input wire csa_reg_pkg::csa_rd_req_t rd,
	input wire logic in_snoop,
	input wire csa_calc_pkg::csa_operands_t snoop_ops,
	input wire logic out_snoop,
	input wire csa_calc_pkg::csa_result_u snoop_res,
	output logic [`CSA_DATA_WIDTH-1:0] rdata,
	output logic [$clog2(`CSA_INST_NUM)-1:0] channel_sel,
	output csa_calc_pkg::csa_times_t calc_times
);

	localparam int SEL_W = $clog2(`CSA_INST_NUM);

	typedef enum logic [1:0] {
		V_IDLE,
		V_WAIT_IN,
		V_WAIT_OUT
	} valid_state_t;

	logic wr_en_q;
	logic [`CSA_ADDR_BITS:0] wr_addr_q;
	logic [`CSA_DATA_WIDTH-1:0] wr_data_q;
	logic chan_changed;
	csa_calc_pkg::csa_operands_t in_snap;
	csa_calc_pkg::csa_result_u out_snap;
	valid_state_t vstate;
	logic in_valid;
	logic out_valid;

	// ####################
	// write capture.
	// ####################

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= wr.wen;
		end
	end

	// one holding word, unstrobed bytes keep the last write.
	always_ff @(posedge axi_mm_clk) begin
		if (wr.wen) begin
			wr_addr_q <= wr.waddr;
			for (int b = 0; b < `CSA_DATA_WIDTH / 8; b++) begin
				if (wr.wstrb[b]) begin
					wr_data_q[8*b +: 8] <= wr.wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			channel_sel <= '0;
			chan_changed <= 1'b0;
			calc_times <= `CSA_DEFAULT_TIMES;
		end else begin
			chan_changed <= 1'b0;
			if (wr_en_q) begin
				if (wr_addr_q == csa_reg_pkg::ADDR_CHANNEL &&
						wr_data_q < `CSA_INST_NUM) begin
					channel_sel <= wr_data_q[SEL_W-1:0];
					chan_changed <= 1'b1;
				end
				if (wr_addr_q == csa_reg_pkg::ADDR_CALC_TIMES) begin
					// zero restores the default count.
					calc_times <= (wr_data_q == '0) ? `CSA_DEFAULT_TIMES : wr_data_q;
				end
			end
		end
	end

	// ####################
	// snapshot and flags.
	// ####################

	always_ff @(posedge axi_mm_clk) begin
		if (in_snoop) begin
			in_snap <= snoop_ops;
		end
		if (out_snoop) begin
			out_snap <= snoop_res;
		end
	end

	// in first, then out, after each channel change.
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			vstate <= V_IDLE;
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (chan_changed) begin
			vstate <= V_WAIT_IN;
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			case (vstate)
				V_WAIT_IN: begin
					if (in_snoop) begin
						in_valid <= 1'b1;
						vstate <= V_WAIT_OUT;
					end
				end
				V_WAIT_OUT: begin
					if (out_snoop) begin
						out_valid <= 1'b1;
						vstate <= V_IDLE;
					end
				end
				default: begin
					vstate <= V_IDLE;
				end
			endcase
		end
	end

	// ####################
	// read mux.
	// ####################

	always_ff @(posedge axi_mm_clk) begin
		if (rd.ren) begin
			case (rd.raddr)
				csa_reg_pkg::ADDR_CHANNEL: rdata <= `CSA_DATA_WIDTH'(channel_sel);
				csa_reg_pkg::ADDR_IN_VALID: rdata <= `CSA_DATA_WIDTH'(in_valid);
				csa_reg_pkg::ADDR_OUT_VALID: rdata <= `CSA_DATA_WIDTH'(out_valid);
				csa_reg_pkg::ADDR_IN_DATA_0: rdata <= `CSA_DATA_WIDTH'(in_snap[0]);
				csa_reg_pkg::ADDR_IN_DATA_1: rdata <= `CSA_DATA_WIDTH'(in_snap[1]);
				csa_reg_pkg::ADDR_IN_DATA_2: rdata <= `CSA_DATA_WIDTH'(in_snap[2]);
				csa_reg_pkg::ADDR_IN_DATA_3: rdata <= `CSA_DATA_WIDTH'(in_snap[3]);
				csa_reg_pkg::ADDR_IN_DATA_4: rdata <= `CSA_DATA_WIDTH'(in_snap[4]);
				csa_reg_pkg::ADDR_OUT_DATA_0: begin
					rdata <= `CSA_DATA_WIDTH'(out_snap.fields.total_lo);
				end
				csa_reg_pkg::ADDR_OUT_DATA_1: begin
					rdata <= `CSA_DATA_WIDTH'(out_snap.fields.total_hi);
				end
				csa_reg_pkg::ADDR_OUT_DATA_2: begin
					rdata <= `CSA_DATA_WIDTH'(out_snap.fields.unit_id);
				end
				csa_reg_pkg::ADDR_CALC_TIMES: rdata <= calc_times;
				default: begin
					rdata <= {csa_reg_pkg::ERR_TAG, {(15 - `CSA_ADDR_BITS){1'b0}}, rd.raddr};
				end
			endcase
		end
	end

	a_wr_capture: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		wr_en_q |-> $past(wr.wen));

endmodule

`default_nettype wire

//--- src/csa_calc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csa_calc_unit #(
	parameter int UNIT_ID = 0
) (
	input wire logic axi_mm_clk,
	input wire logic rst_n,
	input wire logic request,
	input wire csa_calc_pkg::csa_operands_t operands,
	input wire csa_calc_pkg::csa_times_t calc_times,
	input wire logic release_req,
	output logic inuse,
	output logic ready,
	output csa_calc_pkg::csa_result_u result
);

	csa_calc_pkg::csa_operands_t ops_q;
	csa_calc_pkg::csa_times_t remaining;
	logic [31:0] acc;
	logic busy;
	logic [10:0] op_sum;

	// five bytes never exceed 11 bits.
	always_comb begin
		op_sum = '0;
		for (int k = 0; k < 5; k++) begin
			op_sum = op_sum + 11'(ops_q[k]);
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			inuse <= 1'b0;
			ready <= 1'b0;
			busy <= 1'b0;
		end else if (request) begin
			inuse <= 1'b1;
			busy <= 1'b1;
		end else if (release_req) begin
			inuse <= 1'b0;
			ready <= 1'b0;
		end else if (busy && remaining == 32'd1) begin
			busy <= 1'b0;
			ready <= 1'b1;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (request) begin
			ops_q <= operands;
			remaining <= calc_times;
			acc <= '0;
		end else if (busy) begin
			acc <= acc + 32'(op_sum);
			remaining <= remaining - 32'd1;
		end
	end

	always_comb begin
		result.fields.unit_id = 16'(UNIT_ID);
		result.fields.total_hi = acc[31:16];
		result.fields.total_lo = acc[15:0];
	end

	a_no_req_busy: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		request |-> !inuse);

	a_rel_ready: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		release_req |-> ready);

endmodule

`default_nettype wire

//--- src/csa_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

`include "csa_cfg.svh"

module csa_dispatch (
	input wire logic axi_mm_clk,
	input wire logic rst_n,
	input wire logic in_ready,
	input wire csa_calc_pkg::csa_operands_t in_rdata,
	input wire logic [`CSA_INST_NUM-1:0] unit_inuse,
	input wire logic [$clog2(`CSA_INST_NUM)-1:0] channel_sel,
	output logic in_ren,
	output csa_calc_pkg::csa_operands_t operands,
	output logic [`CSA_INST_NUM-1:0] request,
	output logic in_snoop,
	output csa_calc_pkg::csa_operands_t snoop_ops
);

	typedef enum logic [1:0] {
		D_WAIT_FREE,
		D_WAIT_IN,
		D_CAPTURE
	} disp_state_t;

	disp_state_t state;
	logic [$clog2(`CSA_INST_NUM)-1:0] idx;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state <= D_WAIT_FREE;
			idx <= '0;
			in_ren <= 1'b0;
			request <= '0;
			in_snoop <= 1'b0;
		end else begin
			in_ren <= 1'b0;
			request <= '0;
			in_snoop <= 1'b0;
			case (state)
				D_WAIT_FREE: begin
					if (!unit_inuse[idx]) begin
						state <= D_WAIT_IN;
					end
				end
				D_WAIT_IN: begin
					if (in_ready) begin
						in_ren <= 1'b1;
						state <= D_CAPTURE;
					end
				end
				D_CAPTURE: begin
					// FIFO data is valid one cycle after in_ren.
					request[idx] <= 1'b1;
					in_snoop <= (idx == channel_sel);
					idx <= (idx == `CSA_INST_NUM - 1) ? '0 : idx + 1'b1;
					state <= D_WAIT_FREE;
				end
				default: begin
					state <= D_WAIT_FREE;
				end
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (state == D_CAPTURE) begin
			operands <= in_rdata;
		end
	end

	// snapshot sees the same word the unit samples.
	assign snoop_ops = operands;

	a_ren_ready: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		in_ren |-> $past(in_ready));

endmodule

`default_nettype wire

//--- src/csa_collect.sv
`timescale 1ns/10ps
`default_nettype none

`include "csa_cfg.svh"

module csa_collect (
	input wire logic axi_mm_clk,
	input wire logic rst_n,
	input wire logic out_full,
	input wire logic [`CSA_INST_NUM-1:0] unit_ready,
	input wire csa_calc_pkg::csa_result_u [`CSA_INST_NUM-1:0] unit_result,
	input wire logic [$clog2(`CSA_INST_NUM)-1:0] channel_sel,
	output logic out_wen,
	output csa_calc_pkg::csa_result_u out_wdata,
	output logic [`CSA_INST_NUM-1:0] release_req,
	output logic out_snoop,
	output csa_calc_pkg::csa_result_u snoop_res
);

	typedef enum logic {
		C_WAIT_ROOM,
		C_WAIT_READY
	} coll_state_t;

	coll_state_t state;
	logic [$clog2(`CSA_INST_NUM)-1:0] idx;
	logic take;

	// room is checked again so a late full flag holds the result.
	assign take = (state == C_WAIT_READY) && unit_ready[idx] && !out_full;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state <= C_WAIT_ROOM;
			idx <= '0;
			out_wen <= 1'b0;
			release_req <= '0;
			out_snoop <= 1'b0;
		end else begin
			out_wen <= 1'b0;
			release_req <= '0;
			out_snoop <= 1'b0;
			case (state)
				C_WAIT_ROOM: begin
					if (!out_full) begin
						state <= C_WAIT_READY;
					end
				end
				C_WAIT_READY: begin
					if (take) begin
						out_wen <= 1'b1;
						release_req[idx] <= 1'b1;
						out_snoop <= (idx == channel_sel);
						idx <= (idx == `CSA_INST_NUM - 1) ? '0 : idx + 1'b1;
						state <= C_WAIT_ROOM;
					end
				end
				default: begin
					state <= C_WAIT_ROOM;
				end
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (take) begin
			out_wdata <= unit_result[idx];
		end
	end

	assign snoop_res = out_wdata;

	a_no_wen_full: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		out_wen |-> !$past(out_full));

endmodule

`default_nettype wire

//--- src/csa_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "csa_cfg.svh"

module csa_top (
	input wire logic axi_mm_clk,
	input wire logic rst_n,
	input wire csa_reg_pkg::csa_wr_req_t wr,
	input wire csa_reg_pkg::csa_rd_req_t rd,
	output logic [`CSA_DATA_WIDTH-1:0] rdata,
	input wire logic in_ready,
	output logic in_ren,
	input wire csa_calc_pkg::csa_operands_t in_rdata,
	input wire logic out_full,
	output logic out_wen,
	output csa_calc_pkg::csa_result_u out_wdata
);

	logic [$clog2(`CSA_INST_NUM)-1:0] channel_sel;
	csa_calc_pkg::csa_times_t calc_times;
	csa_calc_pkg::csa_operands_t operands;
	csa_calc_pkg::csa_operands_t snoop_ops;
	csa_calc_pkg::csa_result_u snoop_res;
	csa_calc_pkg::csa_result_u [`CSA_INST_NUM-1:0] unit_result;
	logic [`CSA_INST_NUM-1:0] unit_request;
	logic [`CSA_INST_NUM-1:0] unit_release;
	logic [`CSA_INST_NUM-1:0] unit_inuse;
	logic [`CSA_INST_NUM-1:0] unit_ready;
	logic in_snoop;
	logic out_snoop;

	csa_regfile regfile_i (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wr(wr),
		.rd(rd),
		.in_snoop(in_snoop),
		.snoop_ops(snoop_ops),
		.out_snoop(out_snoop),
		.snoop_res(snoop_res),
		.rdata(rdata),
		.channel_sel(channel_sel),
		.calc_times(calc_times)
	);

	csa_dispatch dispatch_i (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.in_ready(in_ready),
		.in_rdata(in_rdata),
		.unit_inuse(unit_inuse),
		.channel_sel(channel_sel),
		.in_ren(in_ren),
		.operands(operands),
		.request(unit_request),
		.in_snoop(in_snoop),
		.snoop_ops(snoop_ops)
	);

	csa_collect collect_i (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.out_full(out_full),
		.unit_ready(unit_ready),
		.unit_result(unit_result),
		.channel_sel(channel_sel),
		.out_wen(out_wen),
		.out_wdata(out_wdata),
		.release_req(unit_release),
		.out_snoop(out_snoop),
		.snoop_res(snoop_res)
	);

	// ####################
	// unit bank.
	// ####################

	for (genvar i = 0; i < `CSA_INST_NUM; i++) begin : g_unit
		csa_calc_unit #(
			.UNIT_ID(i)
		) unit_i (
			.axi_mm_clk(axi_mm_clk),
			.rst_n(rst_n),
			.request(unit_request[i]),
			.operands(operands),
			.calc_times(calc_times),
			.release_req(unit_release[i]),
			.inuse(unit_inuse[i]),
			.ready(unit_ready[i]),
			.result(unit_result[i])
		);
	end

endmodule

`default_nettype wire

//--- tb/csa_tb_clk.sv
`timescale 1ns/10ps
`default_nettype none

module csa_tb_clk #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic axi_mm_clk,
	output logic rst_n
);

	initial begin
		axi_mm_clk = 1'b0;
		forever #(PERIOD_NS / 2) axi_mm_clk = ~axi_mm_clk;
	end

	// release just after an edge, like every other input.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge axi_mm_clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/csa_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "csa_cfg.svh"

module csa_tb;

	localparam int NUM_VEC = 40;
	localparam int NUM_STREAMS = 2;
	localparam int MAX_TIMES = 8;
	localparam int TIMEOUT_CYCLES = NUM_VEC * NUM_STREAMS * (MAX_TIMES + 20) + 2000;

	logic axi_mm_clk;
	logic rst_n;
	csa_reg_pkg::csa_wr_req_t wr;
	csa_reg_pkg::csa_rd_req_t rd;
	logic [`CSA_DATA_WIDTH-1:0] rdata;
	logic in_ready;
	logic in_ren;
	csa_calc_pkg::csa_operands_t in_rdata;
	logic out_full;
	logic out_wen;
	csa_calc_pkg::csa_result_u out_wdata;

	integer seed = 32'h3935_7350;
	int err_count = 0;
	int check_count = 0;
	int test_err_base = 0;
	int recv_count = 0;
	int vec_count = 0;
	bit gate_in = 1'b0;
	bit gate_out = 1'b0;

	// reference model state.
	logic [31:0] hold_model;
	logic [31:0] times_model = `CSA_DEFAULT_TIMES;
	int chan_model = 0;
	csa_calc_pkg::csa_operands_t in_q[$];
	logic [47:0] exp_q[$];
	csa_calc_pkg::csa_operands_t snap_ops;
	csa_calc_pkg::csa_result_u snap_res;

	csa_tb_clk clk_gen_i (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n)
	);

	csa_top csa_top_i (
		.axi_mm_clk(axi_mm_clk),
		.rst_n(rst_n),
		.wr(wr),
		.rd(rd),
		.rdata(rdata),
		.in_ready(in_ready),
		.in_ren(in_ren),
		.in_rdata(in_rdata),
		.out_full(out_full),
		.out_wen(out_wen),
		.out_wdata(out_wdata)
	);

	// ####################
	// helpers.
	// ####################

	function automatic logic rand_bit();
		integer r;
		r = $random(seed);
		return r[0];
	endfunction

	task automatic check_value(input string sig, input logic [47:0] got,
			input logic [47:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("[FAIL] %s: got %h, expected %h", sig, got, exp);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name);
		if (err_count == test_err_base) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_count - test_err_base);
		end
		test_err_base = err_count;
	endtask

	// unstrobed bytes keep whatever the last write left.
	task automatic reg_write(input logic [`CSA_ADDR_BITS:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		@(posedge axi_mm_clk);
		#1;
		wr.wen = 1'b1;
		wr.wstrb = strb;
		wr.waddr = addr;
		wr.wdata = data;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				hold_model[8*b +: 8] = data[8*b +: 8];
			end
		end
		if (addr == csa_reg_pkg::ADDR_CHANNEL && hold_model < `CSA_INST_NUM) begin
			chan_model = int'(hold_model);
		end
		if (addr == csa_reg_pkg::ADDR_CALC_TIMES) begin
			times_model = (hold_model == 0) ? `CSA_DEFAULT_TIMES : hold_model;
		end
		@(posedge axi_mm_clk);
		#1;
		wr.wen = 1'b0;
		@(posedge axi_mm_clk);
	endtask

	task automatic read_check(input logic [`CSA_ADDR_BITS:0] addr, input string sig,
			input logic [31:0] exp);
		@(posedge axi_mm_clk);
		#1;
		rd.ren = 1'b1;
		rd.raddr = addr;
		@(posedge axi_mm_clk);
		#1;
		rd.ren = 1'b0;
		check_value(sig, {16'd0, rdata}, {16'd0, exp});
	endtask

	task automatic run_stream(input bit pressure);
		integer r;
		csa_calc_pkg::csa_operands_t v;
		csa_calc_pkg::csa_result_u res;
		int sum;
		int recv_base;
		logic [31:0] total;
		r = $random(seed);
		reg_write(csa_reg_pkg::ADDR_CALC_TIMES, 32'(r[2:0]) + 32'd1, 4'hf);
		recv_base = recv_count;
		// off the rising edge, away from the FIFO model.
		@(negedge axi_mm_clk);
		for (int n = 0; n < NUM_VEC; n++) begin
			r = $random(seed);
			v[3:0] = r;
			r = $random(seed);
			v[4] = r[7:0];
			sum = 0;
			for (int k = 0; k < 5; k++) begin
				sum += v[k];
			end
			total = times_model * 32'(sum);
			res.fields.unit_id = 16'(vec_count % `CSA_INST_NUM);
			res.fields.total_hi = total[31:16];
			res.fields.total_lo = total[15:0];
			if (vec_count % `CSA_INST_NUM == chan_model) begin
				snap_ops = v;
				snap_res = res;
			end
			in_q.push_back(v);
			exp_q.push_back(res.raw);
			vec_count++;
		end
		gate_in = pressure;
		gate_out = pressure;
		while (exp_q.size() > 0) begin
			@(posedge axi_mm_clk);
		end
		gate_in = 1'b0;
		gate_out = 1'b0;
		// late duplicates show up in the sink.
		repeat (10) @(posedge axi_mm_clk);
		check_value("results received", 48'(recv_count - recv_base), 48'(NUM_VEC));
		check_value("input FIFO level", 48'(in_q.size()), 48'd0);
	endtask

	// ####################
	// FIFO models.
	// ####################

	always @(posedge axi_mm_clk) begin
		#1;
		if (in_ren) begin
			assert (in_q.size() > 0) else begin
				$display("input FIFO read while the FIFO model was empty");
				err_count++;
			end
			if (in_q.size() > 0) begin
				in_rdata = in_q.pop_front();
			end
		end
		in_ready = (in_q.size() > 0) && (!gate_in || rand_bit());
		if (out_wen) begin
			recv_count++;
			assert (exp_q.size() > 0) else begin
				$display("output FIFO write with no result pending");
				err_count++;
			end
			if (exp_q.size() > 0) begin
				check_value("out_wdata", out_wdata.raw, exp_q.pop_front());
			end
		end
		out_full = gate_out && rand_bit();
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge axi_mm_clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the run did not finish", cycles);
		$display("Testbench failed");
		$finish;
	end

	// ####################
	// test sequence.
	// ####################

	initial begin : main
		integer r;
		integer v;
		logic [`CSA_ADDR_BITS:0] addr;
		wr = '0;
		rd = '0;
		in_ready = 1'b0;
		in_rdata = '0;
		out_full = 1'b0;
		wait (rst_n === 1'b1);

		read_check(csa_reg_pkg::ADDR_CALC_TIMES, "calc_times", `CSA_DEFAULT_TIMES);
		r = $random(seed);
		reg_write(csa_reg_pkg::ADDR_CALC_TIMES, r, 4'hf);
		read_check(csa_reg_pkg::ADDR_CALC_TIMES, "calc_times", times_model);
		for (int n = 0; n < 4; n++) begin
			r = $random(seed);
			v = $random(seed);
			reg_write(csa_reg_pkg::ADDR_CALC_TIMES, v, r[3:0]);
			read_check(csa_reg_pkg::ADDR_CALC_TIMES, "calc_times", times_model);
		end
		reg_write(csa_reg_pkg::ADDR_CALC_TIMES, 32'd0, 4'hf);
		read_check(csa_reg_pkg::ADDR_CALC_TIMES, "calc_times", `CSA_DEFAULT_TIMES);
		finish_test("register access");

		read_check(csa_reg_pkg::ADDR_CHANNEL, "channel_sel", 32'd0);
		r = $random(seed);
		reg_write(csa_reg_pkg::ADDR_CHANNEL, 32'd5 + 32'(r[9:0]), 4'hf);
		read_check(csa_reg_pkg::ADDR_CHANNEL, "channel_sel", 32'(chan_model));
		r = $random(seed);
		reg_write(csa_reg_pkg::ADDR_CHANNEL, 32'(r[15:0] % 5), 4'hf);
		read_check(csa_reg_pkg::ADDR_CHANNEL, "channel_sel", 32'(chan_model));
		read_check(csa_reg_pkg::ADDR_IN_VALID, "in_valid", 32'd0);
		read_check(csa_reg_pkg::ADDR_OUT_VALID, "out_valid", 32'd0);
		finish_test("channel select");

		run_stream(1'b0);
		finish_test("result stream");

		read_check(csa_reg_pkg::ADDR_IN_VALID, "in_valid", 32'd1);
		read_check(csa_reg_pkg::ADDR_OUT_VALID, "out_valid", 32'd1);
		for (int k = 0; k < 5; k++) begin
			read_check(csa_reg_pkg::ADDR_IN_DATA_0 + k, $sformatf("in_data_%0d", k),
				32'(snap_ops[k]));
		end
		read_check(csa_reg_pkg::ADDR_OUT_DATA_0, "out_data_0", 32'(snap_res.fields.total_lo));
		read_check(csa_reg_pkg::ADDR_OUT_DATA_1, "out_data_1", 32'(snap_res.fields.total_hi));
		read_check(csa_reg_pkg::ADDR_OUT_DATA_2, "out_data_2", 32'(snap_res.fields.unit_id));
		// a new selection drops both flags that the stream set.
		r = $random(seed);
		reg_write(csa_reg_pkg::ADDR_CHANNEL, 32'(r[15:0] % 5), 4'hf);
		read_check(csa_reg_pkg::ADDR_IN_VALID, "in_valid", 32'd0);
		read_check(csa_reg_pkg::ADDR_OUT_VALID, "out_valid", 32'd0);
		finish_test("snapshot and flags");

		run_stream(1'b1);
		finish_test("back-pressure");

		for (int n = 0; n < 4; n++) begin
			r = $random(seed);
			addr = 11'd12 + 11'(r[10:0] % 2036);
			read_check(addr, "rdata", {16'hE000, 16'(addr)});
		end
		finish_test("unmapped read");

		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/csa_reg_pkg.sv
src/csa_calc_pkg.sv
src/csa_regfile.sv
src/csa_calc_unit.sv
src/csa_dispatch.sv
src/csa_collect.sv
src/csa_top.sv
tb/csa_tb_clk.sv
tb/csa_tb.sv
